/* source/fpuIsaPkg.sv */
`default_nettype none

package fpuIsaPkg;

  typedef logic [31:0] instrT;  // full instruction word
  typedef logic [6:0]  opcodeT; // major opcode, bits 6:0
  typedef logic [2:0]  funct3T; // bits 14:12, width or rounding mode
  typedef logic [6:0]  funct7T; // bits 31:25, funct5 plus format
  typedef logic [4:0]  regAdrT; // register address or rs2 sub-opcode

  ////////////////////////////////////////////////////////////
  // major opcodes
  ////////////////////////////////////////////////////////////
  localparam opcodeT opFLoad  = 7'b0000111; // flw, fld
  localparam opcodeT opFStore = 7'b0100111; // fsw, fsd
  localparam opcodeT opFmadd  = 7'b1000011;
  localparam opcodeT opFmsub  = 7'b1000111;
  localparam opcodeT opFnmsub = 7'b1001011;
  localparam opcodeT opFnmadd = 7'b1001111;
  localparam opcodeT opFpOp   = 7'b1010011; // everything else

  // funct7[6:2] groups under opFpOp
  localparam logic [4:0] f5Add      = 5'b00000;
  localparam logic [4:0] f5Sub      = 5'b00001;
  localparam logic [4:0] f5Mul      = 5'b00010;
  localparam logic [4:0] f5Div      = 5'b00011;
  localparam logic [4:0] f5Sqrt     = 5'b01011;
  localparam logic [4:0] f5Sgnj     = 5'b00100;
  localparam logic [4:0] f5MinMax   = 5'b00101;
  localparam logic [4:0] f5Cmp      = 5'b10100;
  localparam logic [4:0] f5ClassMvX = 5'b11100; // fclass, fmv.x.*
  localparam logic [4:0] f5MvToFp   = 5'b11110; // fmv.*.x
  localparam logic [4:0] f5CvtFp    = 5'b01000; // fcvt between fp formats
  localparam logic [4:0] f5CvtToFp  = 5'b11010; // int -> fp
  localparam logic [4:0] f5CvtToInt = 5'b11000; // fp -> int

  // memory width in funct3
  localparam funct3T f3Word   = 3'b010;
  localparam funct3T f3Double = 3'b011;

  localparam logic [1:0] fmtSingle = 2'b00; // fmt field codes
  localparam logic [1:0] fmtDouble = 2'b01;

  localparam funct3T     frmDynamic = 3'b111; // take fcsr.frm
  localparam logic [1:0] fsOff      = 2'b00;  // mstatus.FS, unit disabled

endpackage

`default_nettype wire

/* source/fpuCtrlPkg.sv */
`default_nettype none

package fpuCtrlPkg;

  typedef logic [1:0] resSelT;  // final result select
  typedef logic [1:0] postSelT; // post-processing select
  typedef logic [2:0] opCtrlT;  // per-unit operation code
  typedef logic [2:0] frmT;     // rounding mode
  typedef logic       fmtT;     // 0 single, 1 double

  ////////////////////////////////////////////////////////////
  // result select
  //        fp        int
  //   00   other     cmp
  //   01   postproc  cvt
  //   10   store     class
  //   11   -         mv
  ////////////////////////////////////////////////////////////
  localparam resSelT resOther = 2'b00;
  localparam resSelT resPost  = 2'b01;
  localparam resSelT resStore = 2'b10;
  localparam resSelT resMove  = 2'b11;

  // post-processing unit source
  localparam postSelT postCvt = 2'b00;
  localparam postSelT postDiv = 2'b01;
  localparam postSelT postFma = 2'b10;

  // opCtrl in the "other" group that means int -> fp move
  localparam opCtrlT opMvToFp = 3'b011;

  localparam fmtT fmtSp = 1'b0;
  localparam fmtT fmtDp = 1'b1;

  ////////////////////////////////////////////////////////////
  // decode table word
  // {regWrite, writeInt, resSel, postSel, opCtrl, divStart, illegal, cvtInt}
  ////////////////////////////////////////////////////////////
  localparam int decWordW = 12;

  typedef logic [decWordW-1:0] decWordT;

  // nothing written, nothing started
  localparam decWordT decWordIllegal = 12'b0_0_00_00_000_0_1_0;

endpackage

`default_nettype wire

/* source/fpuCtrlIf.sv */
`default_nettype none

// one stage worth of FPU control
interface fpuCtrlIf import fpuCtrlPkg::*; ();

  logic    regWrite; // fp register file write
  logic    writeInt; // result goes to integer file
  resSelT  resSel;
  postSelT postSel;
  opCtrlT  opCtrl;
  frmT     frm;
  fmtT     fmt;
  logic    cvtInt;   // fp -> int convert
  logic    divStart; // kick off div/sqrt
  logic    xEn;      // source operand X used
  logic    yEn;
  logic    zEn;

  modport src (
    output regWrite, writeInt, resSel, postSel, opCtrl, frm, fmt,
           cvtInt, divStart, xEn, yEn, zEn
  );

  modport dst (
    input regWrite, writeInt, resSel, postSel, opCtrl, frm, fmt,
          cvtInt, divStart, xEn, yEn, zEn
  );

endinterface

`default_nettype wire

/* source/fpuInstrDecode.sv */
`default_nettype none

module fpuInstrDecode import fpuIsaPkg::*, fpuCtrlPkg::*; (
  input  instrT      instr,    // instruction in decode
  input  logic [1:0] statusFs, // mstatus.FS
  input  frmT        frmReg,   // fcsr rounding mode
  output logic       illegal,  // not a legal FP instruction
  fpuCtrlIf.src      ctrl      // decoded control, enables excluded
);

  opcodeT     opcode;
  funct3T     funct3;
  funct7T     funct7;
  regAdrT     rs2;          // sub-opcode for cvt, sqrt, class, mv
  logic [1:0] fmtField;     // funct7[1:0]
  logic [1:0] fmtCode;      // format after the special cases
  logic       supportedFmt; // single or double only
  logic       memOp;        // load or store
  logic       fpCvt;        // fcvt between fp formats
  decWordT    word;

  // field split
  assign opcode   = instr[6:0];
  assign funct3   = instr[14:12];
  assign funct7   = instr[31:25];
  assign rs2      = instr[24:20];
  assign fmtField = funct7[1:0];

  assign supportedFmt = (fmtField == fmtSingle) | (fmtField == fmtDouble);
  assign memOp        = (opcode == opFLoad) | (opcode == opFStore);
  assign fpCvt        = (opcode == opFpOp) & (funct7[6:2] == f5CvtFp);

  ////////////////////////////////////////////////////////////
  // decode table
  // {regWrite, writeInt, resSel, postSel, opCtrl, divStart, illegal, cvtInt}
  ////////////////////////////////////////////////////////////
  always_comb begin
    word = decWordIllegal; // unmatched encodings fall through to this
    // fpu off, or half/quad format on a non-memory op
    if (statusFs != fsOff && (memOp || supportedFmt)) begin
      case (opcode)
        opFLoad:
          if (funct3 == f3Word || funct3 == f3Double)
            word = 12'b1_0_10_00_000_0_0_0; // flw / fld
        opFStore:
          if (funct3 == f3Word || funct3 == f3Double)
            word = 12'b0_0_10_00_000_0_0_0; // fsw / fsd
        opFmadd:  word = 12'b1_0_01_10_000_0_0_0;
        opFmsub:  word = 12'b1_0_01_10_001_0_0_0;
        opFnmsub: word = 12'b1_0_01_10_010_0_0_0;
        opFnmadd: word = 12'b1_0_01_10_011_0_0_0;
        opFpOp:
          case (funct7[6:2])
            f5Add: word = 12'b1_0_01_10_110_0_0_0; // fma unit, z is addend
            f5Sub: word = 12'b1_0_01_10_111_0_0_0;
            f5Mul: word = 12'b1_0_01_10_100_0_0_0;
            f5Div: word = 12'b1_0_01_01_000_1_0_0; // iterative divider
            f5Sqrt:
              if (rs2 == '0) word = 12'b1_0_01_01_001_1_0_0;
            f5Sgnj:
              case (funct3)
                3'b000:  word = 12'b1_0_00_00_000_0_0_0; // fsgnj
                3'b001:  word = 12'b1_0_00_00_001_0_0_0; // fsgnjn
                3'b010:  word = 12'b1_0_00_00_010_0_0_0; // fsgnjx
                default: word = decWordIllegal;
              endcase
            f5MinMax:
              case (funct3)
                3'b000:  word = 12'b1_0_00_00_110_0_0_0; // fmin
                3'b001:  word = 12'b1_0_00_00_101_0_0_0; // fmax
                default: word = decWordIllegal;
              endcase
            f5Cmp:
              case (funct3)
                3'b010:  word = 12'b0_1_00_00_010_0_0_0; // feq
                3'b001:  word = 12'b0_1_00_00_001_0_0_0; // flt
                3'b000:  word = 12'b0_1_00_00_011_0_0_0; // fle
                default: word = decWordIllegal;
              endcase
            f5ClassMvX:
              if (rs2 == '0 && funct3 == 3'b001) begin
                word = 12'b0_1_10_00_000_0_0_0;          // fclass
              end else if (rs2 == '0 && funct3 == 3'b000) begin
                word = 12'b0_1_11_00_000_0_0_0;          // fmv.x.w / fmv.x.d
              end
            f5MvToFp:
              if (rs2 == '0 && funct3 == 3'b000)
                word = 12'b1_0_00_00_011_0_0_0;          // fmv.w.x / fmv.d.x
            f5CvtFp:
              // destination in funct7, source in rs2, must differ
              if (fmtField == fmtSingle && rs2 == 5'b00001) begin
                word = 12'b1_0_01_00_000_0_0_0;          // fcvt.s.d
              end else if (fmtField == fmtDouble && rs2 == 5'b00000) begin
                word = 12'b1_0_01_00_001_0_0_0;          // fcvt.d.s
              end
            f5CvtToFp:
              // opCtrl {int to fp, 64-bit, signed}
              case (rs2)
                5'b00000: word = 12'b1_0_01_00_101_0_0_0; // from w
                5'b00001: word = 12'b1_0_01_00_100_0_0_0; // from wu
                5'b00010: word = 12'b1_0_01_00_111_0_0_0; // from l
                5'b00011: word = 12'b1_0_01_00_110_0_0_0; // from lu
                default:  word = decWordIllegal;
              endcase
            f5CvtToInt:
              case (rs2)
                5'b00000: word = 12'b0_1_01_00_001_0_0_1; // to w
                5'b00001: word = 12'b0_1_01_00_000_0_0_1; // to wu
                5'b00010: word = 12'b0_1_01_00_011_0_0_1; // to l
                5'b00011: word = 12'b0_1_01_00_010_0_0_1; // to lu
                default:  word = decWordIllegal;
              endcase
            default: word = decWordIllegal;
          endcase
        default: word = decWordIllegal;
      endcase
    end
  end

  assign {ctrl.regWrite, ctrl.writeInt, ctrl.resSel, ctrl.postSel, ctrl.opCtrl,
          ctrl.divStart, illegal, ctrl.cvtInt} = word;

  // 111 picks the dynamic mode from fcsr
  assign ctrl.frm = (funct3 == frmDynamic) ? frmReg : funct3;

  ////////////////////////////////////////////////////////////
  // format
  ////////////////////////////////////////////////////////////
  // memory ops carry width in funct3, fp-fp cvt works in the source format
  assign fmtCode = memOp ? ((funct3 == f3Double) ? fmtDouble : fmtSingle) :
                   fpCvt ? rs2[1:0] :
                           fmtField;

  assign ctrl.fmt = (fmtCode == fmtDouble) ? fmtDp : fmtSp;

endmodule

`default_nettype wire

/* source/fpuOperandEnable.sv */
`default_nettype none

// source operand enables, used for hazard checks and special-case masking
module fpuOperandEnable import fpuCtrlPkg::*; (
  fpuCtrlIf.dst dec, // decoded word
  fpuCtrlIf.src en   // only xEn, yEn, zEn driven here
);

  logic loadStore;  // resStore with no int result
  logic classOp;
  logic mvToFp;     // int -> fp move, lives in the "other" group
  logic cvtOp;      // any convert
  logic sqrtOp;

  assign loadStore = (dec.resSel == resStore) & ~dec.writeInt;
  assign classOp   = (dec.resSel == resStore) & dec.writeInt;
  assign mvToFp    = (dec.resSel == resOther) & dec.regWrite & (dec.opCtrl == opMvToFp);
  assign cvtOp     = (dec.resSel == resPost) & (dec.postSel == postCvt);
  assign sqrtOp    = (dec.resSel == resPost) & (dec.postSel == postDiv) & dec.opCtrl[0];

  // x unused by loads, stores, int -> fp moves and converts
  assign en.xEn = ~(loadStore | mvToFp | (cvtOp & dec.opCtrl[2]));

  // stores still read y for the store data
  assign en.yEn = ~((loadStore & dec.regWrite) | classOp | mvToFp |
                    (dec.resSel == resMove) | cvtOp | sqrtOp);

  // fma group plus add/sub, mul has no addend
  assign en.zEn = (dec.resSel == resPost) & (dec.postSel == postFma) &
                  (~dec.opCtrl[2] | dec.opCtrl[1]);

endmodule

`default_nettype wire

/* source/fpuCtrlPipe.sv */
`default_nettype none

module fpuCtrlPipe import fpuCtrlPkg::*; (
  input  logic    clk,
  input  logic    arstN,
  input  logic    stallE, stallM, stallW,
  input  logic    flushE, flushM, flushW,
  input  logic    fDivBusyE,  // divider still working
  fpuCtrlIf.dst   dec,        // decode stage control
  output logic    regWriteE, regWriteM, regWriteW,
  output logic    writeIntE, writeIntM,
  output resSelT  resSelE, resSelM, resSelW,
  output postSelT postSelE, postSelM,
  output opCtrlT  opCtrlE, opCtrlM,
  output frmT     frmM,
  output fmtT     fmtE, fmtM,
  output logic    cvtIntE, cvtIntW,
  output logic    xEnE, yEnE, zEnE,
  output logic    fDivStartE,
  output logic    fpLoadStoreM
);

  frmT  frmE;    // only needed from M on
  logic cvtIntM;

  ////////////////////////////////////////////////////////////
  // D/E
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      {regWriteE, writeIntE, resSelE, postSelE, opCtrlE} <= '0;
      {frmE, fmtE, cvtIntE, xEnE, yEnE, zEnE}            <= '0;
    end else if (flushE) begin // flush wins over stall
      {regWriteE, writeIntE, resSelE, postSelE, opCtrlE} <= '0;
      {frmE, fmtE, cvtIntE, xEnE, yEnE, zEnE}            <= '0;
    end else if (!stallE) begin
      {regWriteE, writeIntE, resSelE, postSelE, opCtrlE} <=
        {dec.regWrite, dec.writeInt, dec.resSel, dec.postSel, dec.opCtrl};
      {frmE, fmtE, cvtIntE, xEnE, yEnE, zEnE} <=
        {dec.frm, dec.fmt, dec.cvtInt, dec.xEn, dec.yEn, dec.zEn};
    end
  end

  // divide start also loads while busy so a pending start survives a stall
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN)                      fDivStartE <= 1'b0;
    else if (flushE)                 fDivStartE <= 1'b0;
    else if (!stallE || fDivBusyE)   fDivStartE <= dec.divStart;
  end

  ////////////////////////////////////////////////////////////
  // E/M
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      {regWriteM, writeIntM, resSelM, postSelM, opCtrlM, frmM, fmtM, cvtIntM} <= '0;
    end else if (flushM) begin
      {regWriteM, writeIntM, resSelM, postSelM, opCtrlM, frmM, fmtM, cvtIntM} <= '0;
    end else if (!stallM) begin
      {regWriteM, writeIntM, resSelM, postSelM, opCtrlM, frmM, fmtM, cvtIntM} <=
        {regWriteE, writeIntE, resSelE, postSelE, opCtrlE, frmE, fmtE, cvtIntE};
    end
  end

  assign fpLoadStoreM = resSelM[1]; // store/class group, class never writes fp

  ////////////////////////////////////////////////////////////
  // M/W
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN)       {regWriteW, resSelW, cvtIntW} <= '0;
    else if (flushW)  {regWriteW, resSelW, cvtIntW} <= '0;
    else if (!stallW) {regWriteW, resSelW, cvtIntW} <= {regWriteM, resSelM, cvtIntM};
  end

endmodule

`default_nettype wire

/* source/fpuCtrl.sv */
`default_nettype none

module fpuCtrl import fpuIsaPkg::*, fpuCtrlPkg::*; (
  input  logic       clk,
  input  logic       arstN,
  input  logic       stallE, stallM, stallW,
  input  logic       flushE, flushM, flushW,
  input  logic       fDivBusyE,
  input  instrT      instrD,    // instruction in decode
  input  logic [1:0] statusFs,
  input  frmT        frmReg,
  output logic       illegalD,
  output logic       xEnD, yEnD, zEnD,
  output logic       regWriteE, regWriteM, regWriteW,
  output logic       writeIntE, writeIntM,
  output resSelT     resSelE, resSelM, resSelW,
  output postSelT    postSelE, postSelM,
  output opCtrlT     opCtrlE, opCtrlM,
  output frmT        frmM,
  output fmtT        fmtE, fmtM,
  output logic       cvtIntE, cvtIntW,
  output logic       xEnE, yEnE, zEnE,
  output logic       fDivStartE,
  output logic       fpLoadStoreM
);

  fpuCtrlIf decodeBus (); // full decode stage word
  fpuCtrlIf enableBus (); // copy read by the enable logic

  // mirror of the decoded word
  assign {enableBus.regWrite, enableBus.writeInt, enableBus.resSel, enableBus.postSel} =
         {decodeBus.regWrite, decodeBus.writeInt, decodeBus.resSel, decodeBus.postSel};
  assign {enableBus.opCtrl, enableBus.frm, enableBus.fmt, enableBus.cvtInt} =
         {decodeBus.opCtrl, decodeBus.frm, decodeBus.fmt, decodeBus.cvtInt};
  assign {enableBus.divStart, enableBus.xEn, enableBus.yEn, enableBus.zEn} =
         {decodeBus.divStart, decodeBus.xEn, decodeBus.yEn, decodeBus.zEn};

  // D stage enables straight out
  assign xEnD = decodeBus.xEn;
  assign yEnD = decodeBus.yEn;
  assign zEnD = decodeBus.zEn;

  fpuInstrDecode decode (
    .instr(instrD), .statusFs(statusFs), .frmReg(frmReg),
    .illegal(illegalD), .ctrl(decodeBus.src)
  );

  fpuOperandEnable operandEnable (
    .dec(enableBus.dst), .en(decodeBus.src)
  );

  fpuCtrlPipe pipe (
    .clk(clk), .arstN(arstN),
    .stallE(stallE), .stallM(stallM), .stallW(stallW),
    .flushE(flushE), .flushM(flushM), .flushW(flushW),
    .fDivBusyE(fDivBusyE), .dec(decodeBus.dst),
    .regWriteE(regWriteE), .regWriteM(regWriteM), .regWriteW(regWriteW),
    .writeIntE(writeIntE), .writeIntM(writeIntM),
    .resSelE(resSelE), .resSelM(resSelM), .resSelW(resSelW),
    .postSelE(postSelE), .postSelM(postSelM),
    .opCtrlE(opCtrlE), .opCtrlM(opCtrlM), .frmM(frmM),
    .fmtE(fmtE), .fmtM(fmtM), .cvtIntE(cvtIntE), .cvtIntW(cvtIntW),
    .xEnE(xEnE), .yEnE(yEnE), .zEnE(zEnE),
    .fDivStartE(fDivStartE), .fpLoadStoreM(fpLoadStoreM)
  );

endmodule

`default_nettype wire

/* verification/fpuCtrlTb.sv */
`default_nettype none

module fpuCtrlTb import fpuIsaPkg::*, fpuCtrlPkg::*; ();

  logic       clk, arstN;
  logic       stallE, stallM, stallW;
  logic       flushE, flushM, flushW;
  logic       fDivBusyE;
  instrT      instrD;
  logic [1:0] statusFs;
  frmT        frmReg;
  logic       illegalD, xEnD, yEnD, zEnD;
  logic       regWriteE, regWriteM, regWriteW;
  logic       writeIntE, writeIntM;
  resSelT     resSelE, resSelM, resSelW;
  postSelT    postSelE, postSelM;
  opCtrlT     opCtrlE, opCtrlM;
  frmT        frmM;
  fmtT        fmtE, fmtM;
  logic       cvtIntE, cvtIntW;
  logic       xEnE, yEnE, zEnE;
  logic       fDivStartE, fpLoadStoreM;

  string       vecName[$];
  logic [31:0] vecInstr[$];
  logic [1:0]  vecFs[$];
  frmT         vecFrm[$];
  logic        vecIllegal[$];
  logic [2:0]  vecEnD[$];   // {x, y, z}
  logic [14:0] vecCtrlE[$]; // packed E word, see stageWordE

  int errorCount;
  int cycleCount;
  int cycleLimit; // 0 until the vectors are read

  fpuCtrl UUT (.*);

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
    if (cycleLimit != 0 && cycleCount >= cycleLimit)
      abortRun($sformatf("timeout, run passed %0d cycles", cycleLimit));
  end

  //////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////
  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("FAIL: see errors above");
    $fatal(1, "run stopped");
  endtask

  task automatic checkValue(input string testName, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (expected !== actual) begin
      errorCount = errorCount + 1;
      abortRun($sformatf("Error %s: expected %0h, actual %0h", testName, expected, actual));
    end
  endtask

  // same field order as the vector file
  function automatic logic [14:0] stageWordE();
    return {regWriteE, writeIntE, resSelE, postSelE, opCtrlE, fmtE, cvtIntE,
            xEnE, yEnE, zEnE, fDivStartE};
  endfunction

  // upper ten bits of the E word as seen in M
  function automatic logic [9:0] stageWordM();
    return {regWriteM, writeIntM, resSelM, postSelM, opCtrlM, fmtM};
  endfunction

  task automatic readVectors();
    int          fd;
    int          count;
    string       line;
    string       name;
    logic [31:0] instrV, fsV, frmV, illV, xV, yV, zV, ctrlV;
    fd = $fopen("verification/fpuCtrlVectors.txt", "r");
    if (fd == 0) begin
      abortRun("cannot open verification/fpuCtrlVectors.txt");
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() >= 4 && line.substr(0, 1) != "//") begin // skip notes, blanks
          count = $sscanf(line, "%s %h %h %h %h %h %h %h %h", name, instrV, fsV, frmV,
                          illV, xV, yV, zV, ctrlV);
          if (count != 9) begin
            abortRun({"malformed vector line: ", line});
          end else begin
            vecName.push_back(name);
            vecInstr.push_back(instrV);
            vecFs.push_back(fsV[1:0]);
            vecFrm.push_back(frmV[2:0]);
            vecIllegal.push_back(illV[0]);
            vecEnD.push_back({xV[0], yV[0], zV[0]});
            vecCtrlE.push_back(ctrlV[14:0]);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic lookupVector(input string name, output int idx);
    idx = -1;
    foreach (vecName[i]) begin
      if (vecName[i] == name) idx = i;
    end
    if (idx < 0) abortRun({"vector file has no entry for ", name});
  endtask

  task automatic applyVector(input int idx);
    instrD   = vecInstr[idx];
    statusFs = vecFs[idx];
    frmReg   = vecFrm[idx];
  endtask

  // all zero instruction decodes as illegal, so nothing moves down the pipe
  task automatic idleGap();
    int gap;
    gap = $urandom_range(4, 1);
    {stallE, stallM, stallW, flushE, flushM, flushW, fDivBusyE} = '0;
    instrD   = '0;
    statusFs = 2'b01;
    repeat (gap) @(negedge clk);
  endtask

  //////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////
  initial begin
    int idx;
    int idxB;
    void'($urandom(32'h2a71_b845));
    clk   = 1'b0;
    arstN = 1'b0;
    {stallE, stallM, stallW, flushE, flushM, flushW, fDivBusyE} = '0;
    instrD   = '0;
    statusFs = 2'b01; // fs initial so the unit is on
    frmReg   = '0;
    readVectors();
    cycleLimit = 20 * vecName.size() + 200;
    repeat (10) @(negedge clk);
    arstN = 1'b1;

    // decode table with D checked at the edge and E after it
    foreach (vecName[i]) begin
      applyVector(i);
      @(posedge clk);
      checkValue({vecName[i], " illegalD"}, 32'(vecIllegal[i]), 32'(illegalD));
      checkValue({vecName[i], " enablesD"}, 32'(vecEnD[i]), 32'({xEnD, yEnD, zEnD}));
      @(negedge clk);
      checkValue({vecName[i], " wordE"}, 32'(vecCtrlE[i]), 32'(stageWordE()));
    end

    idleGap();
    instrD = 32'h0031_70d3; // fadd.s with dynamic rm
    frmReg = 3'b010;
    repeat (2) @(negedge clk);
    checkValue("frm dynamic", 32'(frmReg), 32'(frmM));
    instrD = 32'h0031_30d3; // fadd.s with static rm rup
    repeat (2) @(negedge clk);
    checkValue("frm static", 32'd3, 32'(frmM));

    idleGap();
    lookupVector("fmul.s", idx);
    lookupVector("fclass.s", idxB);
    applyVector(idx);
    @(negedge clk);
    checkValue("stall load", 32'(vecCtrlE[idx]), 32'(stageWordE()));
    stallE = 1'b1;
    applyVector(idxB); // must not reach E yet
    @(negedge clk);
    checkValue("stall hold", 32'(vecCtrlE[idx]), 32'(stageWordE()));
    flushE = 1'b1;     // flush beats the stall
    @(negedge clk);
    checkValue("flush clear", 32'd0, 32'(stageWordE()));
    flushE = 1'b0;
    stallE = 1'b0;
    @(negedge clk);
    checkValue("flush reload", 32'(vecCtrlE[idxB]), 32'(stageWordE()));

    idleGap();
    lookupVector("fld", idx);
    applyVector(idx);
    @(negedge clk);
    instrD = '0;
    checkValue("load regWriteE", 32'd1, 32'(regWriteE));
    @(negedge clk);
    checkValue("load regWriteM", 32'd1, 32'(regWriteM));
    checkValue("load wordM", 32'(vecCtrlE[idx][14:5]), 32'(stageWordM()));
    checkValue("load fpLoadStoreM", 32'd1, 32'(fpLoadStoreM));
    @(negedge clk);
    checkValue("load regWriteW", 32'd1, 32'(regWriteW));
    checkValue("load resSelW", 32'(vecCtrlE[idx][12:11]), 32'(resSelW));

    idleGap();
    lookupVector("fcvt.w.d", idx);
    applyVector(idx);
    @(negedge clk);
    instrD = '0;
    checkValue("cvt cvtIntE", 32'd1, 32'(cvtIntE));
    @(negedge clk);
    checkValue("cvt wordM", 32'(vecCtrlE[idx][14:5]), 32'(stageWordM()));
    @(negedge clk);
    checkValue("cvt cvtIntW", 32'd1, 32'(cvtIntW));
    checkValue("cvt resSelW", 32'(vecCtrlE[idx][12:11]), 32'(resSelW));

    // divide start survives a stalled edge while the divider is busy
    idleGap();
    checkValue("div idle", 32'd0, 32'(fDivStartE));
    lookupVector("fdiv.d", idx);
    applyVector(idx);
    stallE    = 1'b1;
    fDivBusyE = 1'b1;
    @(negedge clk);
    checkValue("div start held", 32'd1, 32'(fDivStartE));
    checkValue("div stall regWriteE", 32'd0, 32'(regWriteE));
    idleGap();

    if (errorCount == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      $display("FAIL: see errors above");
      $fatal(1, "checks failed");
    end
  end

endmodule

`default_nettype wire

/* verification/fpuCtrlVectors.txt */
// name instr statusFs frmReg illegalD xEnD yEnD zEnD wordE, numbers in hex
// wordE {regWrite writeInt resSel postSel opCtrl fmt cvtInt xEn yEn zEn divStart}
fld        00013087  1  0  0  0  0  0  5020
fsw        00312027  1  0  0  0  1  0  1004
fmadd.s    203100c3  1  0  0  1  1  1  4c0e
fmsub.d    223100c7  1  0  0  1  1  1  4c6e
fnmsub.s   203100cb  1  0  0  1  1  1  4c8e
fnmadd.s   203100cf  1  0  0  1  1  1  4cce
fadd.s     003100d3  1  0  0  1  1  1  4d8e
fsub.d     0a3100d3  1  0  0  1  1  1  4dee
fmul.s     103100d3  1  0  0  1  1  0  4d0c
fdiv.d     1a3100d3  1  0  0  1  1  0  4a2d
fsqrt.s    580100d3  1  0  0  1  0  0  4a49
fsgnjn.d   223110d3  1  0  0  1  1  0  406c
fmax.s     283110d3  1  0  0  1  1  0  414c
flt.d      a23110d3  1  0  0  1  1  0  206c
fclass.s   e00110d3  1  0  0  1  0  0  3008
fmv.x.d    e20100d3  1  0  0  1  0  0  3828
fmv.w.x    f00100d3  1  0  0  0  0  0  40c0
fcvt.s.d   401100d3  1  0  0  1  0  0  4828
fcvt.w.d   c20110d3  1  0  0  1  0  0  2878
fcvt.s.lu  d03100d3  1  0  0  0  0  0  4980
fsOff      003100d3  0  0  1  1  1  0  000c
fadd.q     063100d3  1  0  1  1  1  0  000c
feqBadF3   a03130d3  1  0  1  1  1  0  000c
badOpcode  003100ff  1  0  1  1  1  0  000c

/* src.f */
source/fpuIsaPkg.sv
source/fpuCtrlPkg.sv
source/fpuCtrlIf.sv
source/fpuInstrDecode.sv
source/fpuOperandEnable.sv
source/fpuCtrlPipe.sv
source/fpuCtrl.sv
verification/fpuCtrlTb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
LINTFLAGS := --lint-only -Wall --timing
TOP       := fpuCtrlTb
FILELIST  := src.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_TEXT := PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o $(TOP)

run: build
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
